// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := fp_cvt_unit_tb
FILELIST  := fp_cvt_unit.f
OBJDIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "All checks passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== design/fp_cvt.sv ====
`timescale 1ns/1ps

module fp_cvt import fp_cvt_pkg::*; (
    input  fp_cvt_f2i_in_t  fp_cvt_f2i_i,
    output fp_cvt_f2i_out_t fp_cvt_f2i_o,
    input  fp_cvt_i2f_in_t  fp_cvt_i2f_i,
    output fp_rnd_in_t      fp_cvt_i2f_o,
    input  lzc_64_out_t     lzc_o,
    output lzc_64_in_t      lzc_i
);

    logic         f2i_sign;
    logic         f2i_nan;
    logic         f2i_infs;
    logic [12:0]  f2i_expo;
    logic [6:0]   f2i_limit;
    logic [119:0] f2i_mant;
    logic [64:0]  f2i_uint;
    logic [64:0]  f2i_sgnd;
    logic [2:0]   f2i_grs;
    logic         f2i_odd;
    logic         f2i_inc;
    logic         f2i_big;
    logic         f2i_sat;
    logic         f2i_nonzero;
    logic [4:0]   f2i_or;

    logic         i2f_sign;
    logic [63:0]  i2f_data;
    logic [63:0]  i2f_mant;
    logic [5:0]   i2f_top;
    logic [5:0]   i2f_count;
    logic [63:0]  i2f_norm;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // float to integer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        f2i_sign = fp_cvt_f2i_i.ext.data[64];
        f2i_nan  = fp_cvt_f2i_i.ext.classification[8] | fp_cvt_f2i_i.ext.classification[9];
        f2i_infs = fp_cvt_f2i_i.ext.classification[0] | fp_cvt_f2i_i.ext.classification[7];

        case (fp_cvt_f2i_i.op)
            OP_W:    f2i_limit = 7'd34;
            OP_WU:   f2i_limit = 7'd35;
            OP_L:    f2i_limit = 7'd66;
            default: f2i_limit = 7'd67;
        endcase

        // the integer lsb sits at bit 55 which is three above the hidden bit.
        f2i_expo = {1'b0, fp_cvt_f2i_i.ext.data[63:52]} - 13'(EXT_BIAS - 3);
        f2i_mant = {67'h0, 1'b1, fp_cvt_f2i_i.ext.data[51:0]};
        if (fp_cvt_f2i_i.ext.classification[3] | fp_cvt_f2i_i.ext.classification[4]) begin
            f2i_mant[52] = 1'b0;
        end

        f2i_big = 1'b0;
        if ($signed(f2i_expo) > $signed({6'h0, f2i_limit})) begin
            f2i_big = 1'b1;
        end else if ($signed(f2i_expo) > 0) begin
            f2i_mant = f2i_mant << f2i_expo[6:0];
        end

        f2i_uint = f2i_mant[119:55];
        f2i_grs  = {f2i_mant[54:53], |f2i_mant[52:0]};
        f2i_odd  = f2i_uint[0] | f2i_grs[1] | f2i_grs[0];

        case (fp_cvt_f2i_i.rm)
            RM_RNE:  f2i_inc = f2i_grs[2] & f2i_odd;
            RM_RDN:  f2i_inc = f2i_sign & |f2i_grs;
            RM_RUP:  f2i_inc = ~f2i_sign & |f2i_grs;
            RM_RMM:  f2i_inc = f2i_grs[2];
            default: f2i_inc = 1'b0;
        endcase

        f2i_uint = f2i_uint + {64'h0, f2i_inc};

        f2i_or[4]   = f2i_uint[64];
        f2i_or[3]   = f2i_uint[63];
        f2i_or[2]   = |f2i_uint[62:32];
        f2i_or[1]   = f2i_uint[31];
        f2i_or[0]   = |f2i_uint[30:0];
        f2i_nonzero = |f2i_or;

        // range check on the rounded magnitude.
        case (fp_cvt_f2i_i.op)
            OP_W: begin
                f2i_sat = |f2i_or[4:2] | (f2i_sign ? (f2i_or[1] & f2i_or[0]) : f2i_or[1]);
            end
            OP_WU: begin
                f2i_sat = |f2i_or[4:2] | (f2i_sign & f2i_nonzero);
            end
            OP_L: begin
                f2i_sat = f2i_or[4] | (f2i_sign ? (f2i_or[3] & |f2i_or[2:0]) : f2i_or[3]);
            end
            default: begin
                f2i_sat = f2i_or[4] | (f2i_sign & f2i_nonzero);
            end
        endcase
        f2i_sat = f2i_sat | f2i_big | f2i_infs | f2i_nan;

        f2i_sgnd = f2i_sign ? -f2i_uint : f2i_uint;

        fp_cvt_f2i_o.flags = '0;
        if (f2i_sat) begin
            fp_cvt_f2i_o.flags[FLAG_NV] = 1'b1;
            case (fp_cvt_f2i_i.op)
                OP_W:    fp_cvt_f2i_o.result = (f2i_sign & ~f2i_nan) ? I32_MIN : I32_MAX;
                OP_L:    fp_cvt_f2i_o.result = (f2i_sign & ~f2i_nan) ? I64_MIN : I64_MAX;
                default: fp_cvt_f2i_o.result = (f2i_sign & ~f2i_nan) ? 64'h0 : U_MAX;
            endcase
        end else begin
            fp_cvt_f2i_o.flags[FLAG_NX] = |f2i_grs;
            if (fp_cvt_f2i_i.op[1]) begin
                fp_cvt_f2i_o.result = f2i_sgnd[63:0];
            end else begin
                // rv64 keeps w sign-extended.
                fp_cvt_f2i_o.result = {{32{f2i_sgnd[31]}}, f2i_sgnd[31:0]};
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // integer to float, up to the rounder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (fp_cvt_i2f_i.op)
            OP_W:    i2f_sign = fp_cvt_i2f_i.data[31];
            OP_L:    i2f_sign = fp_cvt_i2f_i.data[63];
            default: i2f_sign = 1'b0;
        endcase

        i2f_data = i2f_sign ? -fp_cvt_i2f_i.data : fp_cvt_i2f_i.data;

        // a 32 bit operand is parked in the upper half.
        if (fp_cvt_i2f_i.op[1]) begin
            i2f_mant = i2f_data;
            i2f_top  = 6'd63;
        end else begin
            i2f_mant = {i2f_data[31:0], 32'h0};
            i2f_top  = 6'd31;
        end

        lzc_i.a = i2f_mant;
    end

    always_comb begin
        i2f_count = ~lzc_o.c;
        i2f_norm  = i2f_mant << i2f_count;

        fp_cvt_i2f_o.sig  = i2f_sign;
        fp_cvt_i2f_o.expo = 14'(i2f_top) + 14'(SP_BIAS) - 14'(i2f_count);
        fp_cvt_i2f_o.mant = i2f_norm[63:40];
        fp_cvt_i2f_o.grs  = {i2f_norm[39:38], |i2f_norm[37:0]};
        fp_cvt_i2f_o.rm   = fp_cvt_i2f_i.rm;
        fp_cvt_i2f_o.zero = ~lzc_o.v;
    end

endmodule

// ==== design/fp_cvt_pkg.sv ====
package fp_cvt_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        F2I = 1'b0,
        I2F = 1'b1
    } cvt_dir_t;

    typedef enum logic [1:0] {
        OP_W  = 2'd0,
        OP_WU = 2'd1,
        OP_L  = 2'd2,
        OP_LU = 2'd3
    } fcvt_op_t;

    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,
        RM_RUP = 3'd3,
        RM_RMM = 3'd4
    } rm_t;

    localparam int FLAG_NV  = 4; // bit positions in the fflags word.
    localparam int FLAG_NX  = 0;
    localparam int SP_BIAS  = 127;
    localparam int EXT_BIAS = 2047; // bias of the 12 bit internal exponent.

    // the saturation values are sign-extended to 64 bits.
    localparam logic [63:0] I32_MAX = 64'h0000_0000_7fff_ffff;
    localparam logic [63:0] I32_MIN = 64'hffff_ffff_8000_0000;
    localparam logic [63:0] I64_MAX = 64'h7fff_ffff_ffff_ffff;
    localparam logic [63:0] I64_MIN = 64'h8000_0000_0000_0000;
    localparam logic [63:0] U_MAX   = 64'hffff_ffff_ffff_ffff;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        cvt_dir_t    dir;
        fcvt_op_t    op;
        rm_t         rm;
        logic [63:0] data; // for F2I the single sits in data[31:0].
    } cvt_req_t;

    typedef struct packed {
        logic [64:0] data;           // sign, 12 bit exponent, 52 bit fraction.
        logic [9:0]  classification; // same bit order as fclass.s.
    } fp_ext_t;

    typedef struct packed {
        fp_ext_t  ext;
        fcvt_op_t op;
        rm_t      rm;
    } fp_cvt_f2i_in_t;

    typedef struct packed {
        logic [63:0] result;
        logic [4:0]  flags;
    } fp_cvt_f2i_out_t;

    typedef struct packed {
        logic [63:0] data;
        fcvt_op_t    op;
        rm_t         rm;
    } fp_cvt_i2f_in_t;

    typedef struct packed {
        logic               sig;
        logic signed [13:0] expo;
        logic [23:0]        mant; // hidden bit at [23].
        logic [2:0]         grs;
        rm_t                rm;
        logic               zero;
    } fp_rnd_in_t;

    typedef struct packed {
        logic [31:0] result;
        logic [4:0]  flags;
    } fp_rnd_out_t;

    typedef struct packed {
        logic [63:0] a;
    } lzc_64_in_t;

    typedef struct packed {
        logic [5:0] c; // index of the highest set bit.
        logic       v;
    } lzc_64_out_t;

endpackage

// ==== design/fp_cvt_unit.sv ====
`timescale 1ns/1ps

module fp_cvt_unit import fp_cvt_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        valid_i,
    input  cvt_req_t    req_i,
    output logic        valid_o,
    output logic [63:0] result_o,
    output logic [4:0]  flags_o
);

    fp_ext_t         ext;
    fp_cvt_f2i_in_t  f2i_in;
    fp_cvt_f2i_out_t f2i_out;
    fp_cvt_i2f_in_t  i2f_in;
    fp_rnd_in_t      rnd_in;
    fp_rnd_out_t     rnd_out;
    lzc_64_in_t      lzc_in;
    lzc_64_out_t     lzc_out;
    logic [63:0]     sel_result;
    logic [4:0]      sel_flags;

    fp_unpack i_unpack (
        .a_i   (req_i.data[31:0]),
        .ext_o (ext)
    );

    assign f2i_in.ext  = ext;
    assign f2i_in.op   = req_i.op;
    assign f2i_in.rm   = req_i.rm;
    assign i2f_in.data = req_i.data;
    assign i2f_in.op   = req_i.op;
    assign i2f_in.rm   = req_i.rm;

    fp_cvt i_cvt (
        .fp_cvt_f2i_i (f2i_in),
        .fp_cvt_f2i_o (f2i_out),
        .fp_cvt_i2f_i (i2f_in),
        .fp_cvt_i2f_o (rnd_in),
        .lzc_o        (lzc_out),
        .lzc_i        (lzc_in)
    );

    lzc_64 i_lzc (
        .lzc_i (lzc_in),
        .lzc_o (lzc_out)
    );

    fp_rnd i_rnd (
        .fp_rnd_i (rnd_in),
        .fp_rnd_o (rnd_out)
    );

    assign sel_result = (req_i.dir == F2I) ? f2i_out.result : {32'h0, rnd_out.result};
    assign sel_flags  = (req_i.dir == F2I) ? f2i_out.flags : rnd_out.flags;

    // single output stage.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
            flags_o  <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                result_o <= sel_result;
                flags_o  <= sel_flags;
            end
        end
    end

endmodule

// ==== design/fp_rnd.sv ====
`timescale 1ns/1ps

module fp_rnd import fp_cvt_pkg::*; (
    input  fp_rnd_in_t  fp_rnd_i,
    output fp_rnd_out_t fp_rnd_o
);

    logic               inexact;
    logic               inc;
    logic [24:0]        mant_sum;
    logic signed [13:0] expo_adj;
    logic [22:0]        frac;

    always_comb begin
        inexact = |fp_rnd_i.grs;

        case (fp_rnd_i.rm)
            RM_RNE: begin
                inc = fp_rnd_i.grs[2] & (fp_rnd_i.mant[0] | |fp_rnd_i.grs[1:0]);
            end
            RM_RDN:  inc = fp_rnd_i.sig & inexact;
            RM_RUP:  inc = ~fp_rnd_i.sig & inexact;
            RM_RMM:  inc = fp_rnd_i.grs[2];
            default: inc = 1'b0; // truncate.
        endcase

        mant_sum = {1'b0, fp_rnd_i.mant} + 25'(inc);
        expo_adj = fp_rnd_i.expo;
        frac     = mant_sum[22:0];

        // a carry out of the mantissa only happens from all ones, so the fraction is zero.
        if (mant_sum[24]) begin
            expo_adj = fp_rnd_i.expo + 14'sd1;
        end

        fp_rnd_o.flags = '0;
        if (fp_rnd_i.zero) begin
            fp_rnd_o.result = 32'h0;
        end else begin
            fp_rnd_o.result = {fp_rnd_i.sig, expo_adj[7:0], frac};
            fp_rnd_o.flags[FLAG_NX] = inexact;
        end
    end

endmodule

// ==== design/fp_unpack.sv ====
`timescale 1ns/1ps

module fp_unpack import fp_cvt_pkg::*; (
    input  logic [31:0] a_i,
    output fp_ext_t     ext_o
);

    logic        sign;
    logic [7:0]  expo;
    logic [22:0] frac;
    logic        exp_zero;
    logic        exp_ones;
    logic        frac_zero;
    logic [4:0]  lz;
    logic [23:0] norm;
    logic [11:0] ext_expo;
    logic [51:0] ext_frac;

    assign sign      = a_i[31];
    assign expo      = a_i[30:23];
    assign frac      = a_i[22:0];
    assign exp_zero  = (expo == 8'h00);
    assign exp_ones  = (expo == 8'hff);
    assign frac_zero = (frac == 23'h0);

    // the priority scan lets the highest set bit of the fraction win.
    always_comb begin
        lz = '0;
        for (int i = 0; i < 23; i++) begin
            if (frac[i]) begin
                lz = 5'(22 - i);
            end
        end
    end

    assign norm = {1'b0, frac} << (lz + 5'd1); // leading one lands on the hidden bit.

    always_comb begin
        if (exp_ones) begin
            ext_expo = 12'hfff;
            ext_frac = {frac, 29'h0};
        end else if (exp_zero & frac_zero) begin
            ext_expo = '0;
            ext_frac = '0;
        end else if (exp_zero) begin
            ext_expo = 12'(EXT_BIAS - SP_BIAS) - {7'h0, lz};
            ext_frac = {norm[22:0], 29'h0};
        end else begin
            ext_expo = {4'h0, expo} + 12'(EXT_BIAS - SP_BIAS);
            ext_frac = {frac, 29'h0};
        end
    end

    assign ext_o.data = {sign, ext_expo, ext_frac};

    assign ext_o.classification[0] = sign & exp_ones & frac_zero;
    assign ext_o.classification[1] = sign & ~exp_zero & ~exp_ones;
    assign ext_o.classification[2] = sign & exp_zero & ~frac_zero;
    assign ext_o.classification[3] = sign & exp_zero & frac_zero;
    assign ext_o.classification[4] = ~sign & exp_zero & frac_zero;
    assign ext_o.classification[5] = ~sign & exp_zero & ~frac_zero;
    assign ext_o.classification[6] = ~sign & ~exp_zero & ~exp_ones;
    assign ext_o.classification[7] = ~sign & exp_ones & frac_zero;
    assign ext_o.classification[8] = exp_ones & ~frac_zero & ~frac[22]; // signaling nan.
    assign ext_o.classification[9] = exp_ones & frac[22];

endmodule

// ==== design/lzc_64.sv ====
`timescale 1ns/1ps

module lzc_64 import fp_cvt_pkg::*; (
    input  lzc_64_in_t  lzc_i,
    output lzc_64_out_t lzc_o
);

    // level l holds 64>>l nodes and node n covers bits [n*2^l +: 2^l].
    logic [63:0] v_lvl [7];
    logic [5:0]  c_lvl [7][64];

    always_comb begin
        v_lvl[0] = lzc_i.a;
        for (int n = 0; n < 64; n++) begin
            c_lvl[0][n] = '0;
        end
        for (int l = 1; l < 7; l++) begin
            v_lvl[l] = '0;
            for (int n = 0; n < 64; n++) begin
                c_lvl[l][n] = '0;
            end
            for (int n = 0; n < (64 >> l); n++) begin
                v_lvl[l][n] = v_lvl[l-1][2*n] | v_lvl[l-1][2*n+1];
                if (v_lvl[l-1][2*n+1]) begin
                    c_lvl[l][n] = c_lvl[l-1][2*n+1] | 6'(1 << (l - 1)); // upper half wins.
                end else begin
                    c_lvl[l][n] = c_lvl[l-1][2*n];
                end
            end
        end
    end

    assign lzc_o.c = c_lvl[6][0];
    assign lzc_o.v = v_lvl[6][0];

endmodule

// ==== fp_cvt_unit.f ====
design/fp_cvt_pkg.sv
design/lzc_64.sv
design/fp_unpack.sv
design/fp_cvt.sv
design/fp_rnd.sv
design/fp_cvt_unit.sv
testbench/fp_cvt_unit_tb.sv

// ==== testbench/fp_cvt_unit_tb.sv ====
`timescale 1ns/1ps

module fp_cvt_unit_tb import fp_cvt_pkg::*;;

    localparam int NUM_REQ     = 4000;
    localparam int DRAIN_LIMIT = 8;

    logic        clk_i;
    logic        rst_n_i;
    logic        valid_i;
    cvt_req_t    req_i;
    logic        valid_o;
    logic [63:0] result_o;
    logic [4:0]  flags_o;

    logic [31:0] lfsr_state;
    int          errors;
    logic        exp_valid;
    logic [63:0] exp_result;
    logic [4:0]  exp_flags;
    logic [68:0] exp_word;

    fp_cvt_unit i_dut (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .valid_i  (valid_i),
        .req_i    (req_i),
        .valid_o  (valid_o),
        .result_o (result_o),
        .flags_o  (flags_o)
    );

    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random numbers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // taps of x^32 + x^22 + x^2 + x + 1.
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], lfsr_step()};
        end
        return r;
    endfunction

    function automatic logic [63:0] pick_int(input logic wide);
        logic [63:0] x;
        case (rand_bits(3))
            0: x = '0;
            1: x = 64'h1 << (wide ? rand_bits(6) : rand_bits(5));
            2: x = rand_bits(8);
            3: begin
                case (rand_bits(3))
                    0: x = 64'h0000_0000_7fff_ffff;
                    1: x = 64'hffff_ffff_8000_0000;
                    2: x = 64'h0000_0000_ffff_ffff;
                    3: x = 64'h7fff_ffff_ffff_ffff;
                    4: x = 64'h8000_0000_0000_0000;
                    5: x = 64'h0100_0003_0000_0000; // exact tie at 64 bits.
                    default: x = '1;
                endcase
            end
            default: x = rand_bits(64);
        endcase
        if (rand_bits(2) == 0) begin
            x = -x;
        end
        return x;
    endfunction

    function automatic logic [31:0] pick_float();
        logic        s;
        logic [7:0]  e;
        logic [22:0] m;
        s = 1'(rand_bits(1));
        e = 8'(rand_bits(8));
        m = 23'(rand_bits(23));
        case (rand_bits(3))
            0: begin
                e = 8'hff; // inf and both nan kinds.
                case (rand_bits(2))
                    0: m = '0;
                    1: m[22] = 1'b1;
                    2: m = {1'b0, m[21:1], 1'b1};
                    default: e = '0;
                endcase
            end
            1: e = '0;
            2: e = 8'(156 + rand_bits(3)); // around the 32 bit limits.
            3: e = 8'(188 + rand_bits(3));
            4: e = 8'(120 + rand_bits(5));
            5: begin
                m = '0;
                e = 8'(110 + rand_bits(6));
            end
            default: ;
        endcase
        return {s, e, m};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [68:0] model_i2f(input logic [63:0] data, input fcvt_op_t op,
                                              input rm_t rm);
        logic        sign;
        logic [31:0] lo;
        logic [63:0] mag;
        logic [63:0] kept;
        logic [63:0] rem;
        logic [63:0] half;
        logic        inc;
        logic [4:0]  flags;
        int          p;
        int          sh;
        sign  = (op == OP_W && data[31]) || (op == OP_L && data[63]);
        lo    = data[31:0];
        mag   = data;
        flags = '0;
        if (op == OP_W || op == OP_WU) begin
            if (sign) begin
                lo = -lo;
            end
            mag = {32'h0, lo};
        end else if (sign) begin
            mag = -data;
        end
        if (mag == 0) begin
            return '0;
        end
        p = 0;
        for (int i = 0; i < 64; i++) begin
            if (mag[i]) begin
                p = i;
            end
        end
        if (p <= 23) begin
            kept = mag << (23 - p); // fits in 24 bits so nothing is lost.
            return {32'h0, sign, 8'(p + 127), kept[22:0], flags};
        end
        sh   = p - 23;
        kept = mag >> sh;
        rem  = mag & ((64'h1 << sh) - 64'h1);
        half = 64'h1 << (sh - 1);
        case (rm)
            RM_RNE:  inc = (rem > half) || (rem == half && kept[0]);
            RM_RDN:  inc = sign && rem != 0;
            RM_RUP:  inc = !sign && rem != 0;
            RM_RMM:  inc = rem >= half;
            default: inc = 1'b0;
        endcase
        kept = kept + 64'(inc);
        if (kept[24]) begin
            kept = kept >> 1;
            p++;
        end
        flags[FLAG_NX] = (rem != 0);
        return {32'h0, sign, 8'(p + 127), kept[22:0], flags};
    endfunction

    function automatic logic [68:0] model_f2i(input logic [31:0] f, input fcvt_op_t op,
                                              input rm_t rm);
        logic         sign;
        logic [7:0]   e;
        logic [23:0]  mant;
        logic [127:0] mag;
        logic [127:0] pos_max;
        logic [127:0] neg_max;
        logic [63:0]  sat_hi;
        logic [63:0]  sat_lo;
        logic [63:0]  rem;
        logic [63:0]  half;
        logic [63:0]  v;
        logic         above;
        logic         tie;
        logic         inexact;
        logic         inc;
        logic [4:0]   flags;
        int           sh;
        case (op)
            OP_W: begin
                pos_max = 128'h7fff_ffff;
                neg_max = 128'h8000_0000;
                sat_hi  = 64'h0000_0000_7fff_ffff;
                sat_lo  = 64'hffff_ffff_8000_0000;
            end
            OP_L: begin
                pos_max = 128'h7fff_ffff_ffff_ffff;
                neg_max = 128'h8000_0000_0000_0000;
                sat_hi  = 64'h7fff_ffff_ffff_ffff;
                sat_lo  = 64'h8000_0000_0000_0000;
            end
            default: begin
                pos_max = (op == OP_WU) ? 128'hffff_ffff : 128'hffff_ffff_ffff_ffff;
                neg_max = '0;
                sat_hi  = '1;
                sat_lo  = '0;
            end
        endcase
        sign    = f[31];
        e       = f[30:23];
        flags   = '0;
        above   = 1'b0;
        tie     = 1'b0;
        inexact = 1'b0;
        if (e == 8'hff) begin
            flags[FLAG_NV] = 1'b1; // a nan saturates high whatever its sign.
            return {(sign && f[22:0] == 0) ? sat_lo : sat_hi, flags};
        end
        mant = (e == 0) ? {1'b0, f[22:0]} : {1'b1, f[22:0]};
        sh   = ((e == 0) ? 1 : int'(e)) - 150;
        if (sh >= 0) begin
            mag = 128'(mant) << sh;
        end else if (sh > -26) begin
            mag     = 128'(mant >> (-sh));
            rem     = 64'(mant) & ((64'h1 << (-sh)) - 64'h1);
            half    = 64'h1 << (-sh - 1);
            inexact = rem != 0;
            above   = rem > half;
            tie     = rem == half;
        end else begin
            mag     = '0; // far below one half.
            inexact = mant != 0;
        end
        case (rm)
            RM_RNE:  inc = above || (tie && mag[0]);
            RM_RDN:  inc = sign && inexact;
            RM_RUP:  inc = !sign && inexact;
            RM_RMM:  inc = above || tie;
            default: inc = 1'b0;
        endcase
        mag = mag + 128'(inc);
        if ((!sign && mag > pos_max) || (sign && mag > neg_max)) begin
            flags[FLAG_NV] = 1'b1;
            return {sign ? sat_lo : sat_hi, flags};
        end
        v = sign ? -mag[63:0] : mag[63:0];
        if (op == OP_W || op == OP_WU) begin
            v = {{32{v[31]}}, v[31:0]};
        end
        flags[FLAG_NX] = inexact;
        return {v, flags};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks and stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic report_mismatch(input string name, input logic [63:0] want,
                                   input logic [63:0] got);
        errors++;
        $display("[FAIL] t=%0t %s expected %h got %h", $time, name, want, got);
    endtask

    task automatic check_outputs();
        if (valid_o !== exp_valid) begin
            report_mismatch("valid_o", 64'(exp_valid), 64'(valid_o));
        end
        if (result_o !== exp_result) begin
            report_mismatch("result_o", exp_result, result_o);
        end
        if (flags_o !== exp_flags) begin
            report_mismatch("flags_o", 64'(exp_flags), 64'(flags_o));
        end
    endtask

    initial begin
        lfsr_state = 32'd91;
        errors     = 0;
        rst_n_i    = 1'b0;
        valid_i    = 1'b0;
        req_i      = '0;
        exp_valid  = 1'b0;
        exp_result = '0;
        exp_flags  = '0;

        repeat (3) begin
            @(posedge clk_i);
            #1;
            check_outputs();
        end
        rst_n_i = 1'b1;

        for (int n = 0; n < NUM_REQ; n++) begin
            valid_i   = (n != 0) && (rand_bits(3) != 0); // idle first cycle and random gaps.
            req_i.dir = cvt_dir_t'(1'(rand_bits(1)));
            req_i.op  = fcvt_op_t'(2'(rand_bits(2)));
            req_i.rm  = rm_t'(3'(rand_bits(8) % 5));
            if (req_i.dir == F2I) begin
                req_i.data = {32'(rand_bits(32)), pick_float()};
                exp_word   = model_f2i(req_i.data[31:0], req_i.op, req_i.rm);
            end else begin
                req_i.data = pick_int(req_i.op == OP_L || req_i.op == OP_LU);
                exp_word   = model_i2f(req_i.data, req_i.op, req_i.rm);
            end
            exp_valid = valid_i;
            if (valid_i) begin
                exp_result = exp_word[68:5];
                exp_flags  = exp_word[4:0];
            end
            @(posedge clk_i);
            #1;
            check_outputs();
        end

        valid_i = 1'b0;
        for (int t = 0; valid_o === 1'b1; t++) begin
            if (t == DRAIN_LIMIT) begin
                $display("timeout: valid_o stayed high after valid_i went low");
                errors++;
                break;
            end
            @(posedge clk_i);
            #1;
        end

        $display("requests: %0d, errors: %0d", NUM_REQ, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
